/* Bender.yml */
package:
  name: udp_rx_out_steer

sources:
  - files:
      - logic/steer_pkg.sv
      - logic/noc_msg_splitter.sv
      - logic/noc_data_to_ctrl.sv
      - logic/udp_rx_out_steer.sv
  - target: simulation
    files:
      - sim/clk_rst_gen.sv
      - sim/udp_rx_out_steer_tb.sv

/* logic/noc_data_to_ctrl.sv */
`timescale 1ns/1ns
module noc_data_to_ctrl (
     input  logic                               clk
    ,input  logic                               arst_n

    ,input  logic                               src_val
    ,input  logic [steer_pkg::NOC_DATA_W-1:0]   src_data
    ,output logic                               src_rdy

    ,output logic                               dst_val
    ,output logic [steer_pkg::CTRL_NOC_W-1:0]   dst_data
    ,input  logic                               dst_rdy
);

    import steer_pkg::*;

    dtc_state_e                 state_r;
    dtc_state_e                 state_nxt;

    logic [NOC_DATA_W-1:0]      flit_r;
    logic [MSG_LEN_W-1:0]       body_left_r;    // Zero means the next flit is a header

    logic                       src_xfer;
    logic                       dst_xfer;
    logic                       in_hdr;

    noc_hdr_flit_t              hdr_in;
    noc_hdr_flit_t              hdr_ctrl;

    assign hdr_in = src_data;
    assign in_hdr = (body_left_r == '0);

    // Each data flit becomes two control flits, plus the header itself
    always_comb begin
        hdr_ctrl         = hdr_in;
        hdr_ctrl.msg_len = {hdr_in.msg_len[MSG_LEN_W-2:0], 1'b1};
    end

    assign src_rdy  = (state_r == DTC_EMPTY) | ((state_r == DTC_LO) & dst_rdy);
    assign src_xfer = src_val & src_rdy;

    assign dst_val  = (state_r != DTC_EMPTY);
    assign dst_xfer = dst_val & dst_rdy;
    assign dst_data = (state_r == DTC_HI) ? flit_r[NOC_DATA_W-1 -: CTRL_NOC_W]
                                          : flit_r[CTRL_NOC_W-1:0];

    always_comb begin
        state_nxt = state_r;
        case (state_r)
            DTC_EMPTY: begin
                if (src_xfer) begin
                    state_nxt = DTC_HI;
                end
            end

            DTC_HI: begin
                if (dst_xfer) begin
                    state_nxt = DTC_LO;
                end
            end

            DTC_LO: begin
                // Back to back when the next flit is waiting
                if (dst_xfer) begin
                    state_nxt = src_xfer ? DTC_HI : DTC_EMPTY;
                end
            end

            default: state_nxt = DTC_EMPTY;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_r     <= DTC_EMPTY;
            body_left_r <= '0;
        end else begin
            state_r <= state_nxt;
            if (src_xfer) begin
                body_left_r <= in_hdr ? hdr_in.msg_len : body_left_r - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (src_xfer) begin
            flit_r <= in_hdr ? hdr_ctrl : src_data;
        end
    end

endmodule

/* logic/noc_msg_splitter.sv */
`timescale 1ns/1ns
module noc_msg_splitter (
     input  logic                                                           clk
    ,input  logic                                                           arst_n

    ,input  logic                                                           src_val
    ,input  logic [steer_pkg::NOC_DATA_W-1:0]                               src_data
    ,output logic                                                           src_rdy

    ,output logic [steer_pkg::NUM_TARGETS-1:0]                              dst_val
    ,output logic [steer_pkg::NUM_TARGETS-1:0][steer_pkg::NOC_DATA_W-1:0]   dst_data
    ,input  logic [steer_pkg::NUM_TARGETS-1:0]                              dst_rdy

    ,output steer_pkg::noc_hdr_flit_t                                       noc_line

    ,input  logic [steer_pkg::NUM_TARGETS-1:0]                              dst_sel_one_hot
);

    import steer_pkg::*;

    split_state_e               state_r;
    split_state_e               state_nxt;

    logic [NUM_TARGETS-1:0]     sel_r;      // Target of the message in progress
    logic [NUM_TARGETS-1:0]     sel_cur;

    logic [MSG_LEN_W-1:0]       body_cnt_r;
    logic [MSG_LEN_W-1:0]       body_cnt_nxt;

    logic                       src_xfer;
    logic                       hdr_xfer;
    noc_hdr_flit_t              src_hdr;

    // Current flit seen as a header, only meaningful in SPLIT_HDR
    assign src_hdr  = src_data;
    assign noc_line = src_hdr;

    // Header flits follow the live select, body flits the latched one
    assign sel_cur = (state_r == SPLIT_HDR) ? dst_sel_one_hot : sel_r;

    always_comb begin
        for (int i = 0; i < NUM_TARGETS; i++) begin
            dst_val[i]  = src_val & sel_cur[i];
            dst_data[i] = src_data;
        end
    end

    assign src_rdy  = |(sel_cur & dst_rdy);
    assign src_xfer = src_val & src_rdy;
    assign hdr_xfer = src_xfer & (state_r == SPLIT_HDR);

    always_comb begin
        state_nxt    = state_r;
        body_cnt_nxt = body_cnt_r;

        case (state_r)
            SPLIT_HDR: begin
                // A zero-length message is complete with its header
                if (src_xfer && (src_hdr.msg_len != '0)) begin
                    state_nxt    = SPLIT_BODY;
                    body_cnt_nxt = src_hdr.msg_len;
                end
            end

            SPLIT_BODY: begin
                if (src_xfer) begin
                    body_cnt_nxt = body_cnt_r - 1'b1;
                    if (body_cnt_r == MSG_LEN_W'(1)) begin
                        state_nxt = SPLIT_HDR;  // Last body flit
                    end
                end
            end

            default: begin
                state_nxt    = SPLIT_HDR;
                body_cnt_nxt = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_r    <= SPLIT_HDR;
            body_cnt_r <= '0;
        end else begin
            state_r    <= state_nxt;
            body_cnt_r <= body_cnt_nxt;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel_r <= '0;
        end else if (hdr_xfer) begin
            sel_r <= dst_sel_one_hot;
        end
    end

endmodule

/* logic/steer_pkg.sv */
package steer_pkg;

    // Stream widths
    localparam int NOC_DATA_W   = 64;
    localparam int CTRL_NOC_W   = 32;

    // Length field and its supported range
    localparam int MSG_LEN_W    = 8;
    localparam int MSG_LEN_MAX  = 127;  // 2*len+1 must still fit in MSG_LEN_W

    localparam logic [3:0] PKT_IF_FBITS = 4'd2;  // Destination of the data NoC output

    localparam int NUM_TARGETS  = 2;

    typedef enum logic [7:0] {
        UDP_RX_DATA = 8'h01,
        UDP_RX_META = 8'h02,
        UDP_RX_CTRL = 8'h03
    } msg_type_e;

    // Header flit, MSB first
    typedef struct packed {
        logic [7:0]             dst_x;
        logic [7:0]             dst_y;
        logic [3:0]             dst_fbits;
        logic [MSG_LEN_W-1:0]   msg_len;    // Body flits that follow
        logic [7:0]             src_x;
        logic [7:0]             src_y;
        logic [3:0]             src_fbits;
        msg_type_e              msg_type;
        logic [7:0]             pad;
    } noc_hdr_flit_t;

    typedef enum logic {
        SPLIT_HDR,
        SPLIT_BODY
    } split_state_e;

    typedef enum logic [1:0] {
        DTC_EMPTY,
        DTC_HI,
        DTC_LO
    } dtc_state_e;

endpackage

/* logic/udp_rx_out_steer.sv */
`timescale 1ns/1ns
module udp_rx_out_steer (
     input  logic                               clk
    ,input  logic                               arst_n

    ,input  logic                               in_val
    ,input  logic [steer_pkg::NOC_DATA_W-1:0]   in_data
    ,output logic                               in_rdy

    ,output logic                               data_out_val
    ,output logic [steer_pkg::NOC_DATA_W-1:0]   data_out_data
    ,input  logic                               data_out_rdy

    ,output logic                               ctrl_out_val
    ,output logic [steer_pkg::CTRL_NOC_W-1:0]   ctrl_out_data
    ,input  logic                               ctrl_out_rdy
);

    import steer_pkg::*;

    logic [NUM_TARGETS-1:0]     dst_sel;
    noc_hdr_flit_t              splitter_line;

    // Full-width line towards the converter
    logic                       line_val;
    logic [NOC_DATA_W-1:0]      line_data;
    logic                       line_rdy;

    noc_msg_splitter flit_steer (
         .clk               (clk                            )
        ,.arst_n            (arst_n                         )

        ,.src_val           (in_val                         )
        ,.src_data          (in_data                        )
        ,.src_rdy           (in_rdy                         )

        ,.dst_val           ({line_val, data_out_val}       )
        ,.dst_data          ({line_data, data_out_data}     )
        ,.dst_rdy           ({line_rdy, data_out_rdy}       )

        ,.noc_line          (splitter_line                  )

        ,.dst_sel_one_hot   (dst_sel                        )
    );

    // Target 0 is the packet interface, everything else goes to control
    assign dst_sel = (splitter_line.dst_fbits == PKT_IF_FBITS) ? 2'b01 : 2'b10;

    noc_data_to_ctrl noc_dtc (
         .clk       (clk            )
        ,.arst_n    (arst_n         )

        ,.src_val   (line_val       )
        ,.src_data  (line_data      )
        ,.src_rdy   (line_rdy       )

        ,.dst_val   (ctrl_out_val   )
        ,.dst_data  (ctrl_out_data  )
        ,.dst_rdy   (ctrl_out_rdy   )
    );

endmodule

/* sim/clk_rst_gen.sv */
`timescale 1ns/1ns
module clk_rst_gen (
     output logic   clk
    ,output logic   arst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

    // Reset held for 10 cycles, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
    end

endmodule

/* sim/udp_rx_out_steer_tb.sv */
`timescale 1ns/1ns
module udp_rx_out_steer_tb;

    import steer_pkg::*;

    localparam int          NUM_TESTS  = 6;
    localparam int          WAIT_LIMIT = 5000;
    localparam logic [31:0] SEED       = 32'h4495_b582;

    logic                   clk;
    logic                   arst_n;

    logic                   in_val;
    logic [NOC_DATA_W-1:0]  in_data;
    logic                   in_rdy;
    logic                   data_out_val;
    logic [NOC_DATA_W-1:0]  data_out_data;
    logic                   data_out_rdy;
    logic                   ctrl_out_val;
    logic [CTRL_NOC_W-1:0]  ctrl_out_data;
    logic                   ctrl_out_rdy;

    // Test table, message 0 sits in the lowest nibble / byte
    string                  t_name     [NUM_TESTS];
    int                     t_msgs     [NUM_TESTS];
    logic [23:0]            t_fbits    [NUM_TESTS];
    logic [47:0]            t_len      [NUM_TESTS];
    int                     t_bp       [NUM_TESTS];    // Percent of cycles with ready low
    int                     t_exp_data [NUM_TESTS];
    int                     t_exp_ctrl [NUM_TESTS];

    logic [NOC_DATA_W-1:0]  exp_data_q [$];
    logic [CTRL_NOC_W-1:0]  exp_ctrl_q [$];

    logic [31:0]            pay_state;
    logic [31:0]            rdy_state;
    int                     bp_pct;
    string                  cur_name;
    int                     err_cnt;
    int                     tests_failed;
    int                     data_seen;
    int                     ctrl_seen;

    clk_rst_gen clk_gen (
         .clk       (clk    )
        ,.arst_n    (arst_n )
    );

    udp_rx_out_steer DUT (
         .clk               (clk            )
        ,.arst_n            (arst_n         )
        ,.in_val            (in_val         )
        ,.in_data           (in_data        )
        ,.in_rdy            (in_rdy         )
        ,.data_out_val      (data_out_val   )
        ,.data_out_data     (data_out_data  )
        ,.data_out_rdy      (data_out_rdy   )
        ,.ctrl_out_val      (ctrl_out_val   )
        ,.ctrl_out_data     (ctrl_out_data  )
        ,.ctrl_out_rdy      (ctrl_out_rdy   )
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        pay_state = lcg_next(pay_state);
        return pay_state;
    endfunction

    function automatic logic [63:0] make_hdr(input logic [31:0] r0, input logic [31:0] r1,
                                             input logic [3:0] fbits, input logic [7:0] len);
        logic [7:0] mtype;
        mtype = (fbits == PKT_IF_FBITS) ? 8'(UDP_RX_DATA) : 8'(UDP_RX_CTRL);
        return {r0[31:24], r0[23:16], fbits, len, r0[15:8], r0[7:0], r1[3:0], mtype, 8'h00};
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch in %s (%s): expected %0h, actual %0h", cur_name, what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic set_row(input int i, input string name, input int msgs,
                           input logic [23:0] fbits, input logic [47:0] lens, input int bp,
                           input int exp_data, input int exp_ctrl);
        t_name[i]     = name;
        t_msgs[i]     = msgs;
        t_fbits[i]    = fbits;
        t_len[i]      = lens;
        t_bp[i]       = bp;
        t_exp_data[i] = exp_data;
        t_exp_ctrl[i] = exp_ctrl;
    endtask

    // Control flits are expected high half first
    task automatic push_ctrl(input logic [63:0] flit);
        exp_ctrl_q.push_back(flit[63:32]);
        exp_ctrl_q.push_back(flit[31:0]);
    endtask

    // A message for the data output stalls the input exactly when that output does
    task automatic send_flit(input logic [63:0] flit, input logic to_data);
        int waited;
        waited  = 0;
        in_val  = 1'b1;
        in_data = flit;
        @(negedge clk);
        if (to_data) begin
            check_value("input ready", data_out_rdy, in_rdy);
        end
        while (!in_rdy) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run($sformatf("timeout in %s: input flit never accepted", cur_name));
            end
            @(negedge clk);
            if (to_data) begin
                check_value("input ready", data_out_rdy, in_rdy);
            end
        end
        @(posedge clk);
        #1;
        in_val = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_data_q.size() != 0 || exp_ctrl_q.size() != 0) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run($sformatf("timeout in %s: %0d data and %0d ctrl flits never came out",
                                    cur_name, exp_data_q.size(), exp_ctrl_q.size()));
            end
            @(posedge clk);
        end
        repeat (4) @(posedge clk);   // Room for any extra flit to show up
    endtask

    task automatic run_test(input int t);
        logic [31:0]    r0;
        logic [31:0]    r1;
        logic [63:0]    flit;
        logic [3:0]     fb;
        logic [7:0]     len;
        int             err_before;
        @(negedge clk);
        cur_name   = t_name[t];
        bp_pct     = t_bp[t];
        data_seen  = 0;
        ctrl_seen  = 0;
        err_before = err_cnt;
        @(posedge clk);
        #1;
        for (int m = 0; m < t_msgs[t]; m++) begin
            fb = t_fbits[t][m*4 +: 4];
            len = t_len[t][m*8 +: 8];
            r0 = next_rand();
            r1 = next_rand();
            flit = make_hdr(r0, r1, fb, len);
            if (fb == PKT_IF_FBITS) begin
                exp_data_q.push_back(flit);
            end else begin
                push_ctrl(make_hdr(r0, r1, fb, 8'(2 * len + 1)));  // Length in control flits
            end
            send_flit(flit, fb == PKT_IF_FBITS);
            for (int b = 0; b < len; b++) begin
                r0 = next_rand();
                r1 = next_rand();
                flit = {r0, r1};
                if (fb == PKT_IF_FBITS) begin
                    exp_data_q.push_back(flit);
                end else begin
                    push_ctrl(flit);
                end
                send_flit(flit, fb == PKT_IF_FBITS);
            end
        end
        wait_drain();
        check_value("data flit count", t_exp_data[t], data_seen);
        check_value("ctrl flit count", t_exp_ctrl[t], ctrl_seen);
        if (err_cnt != err_before) begin
            tests_failed++;
        end
        $display("test %-13s %-6s data %0d ctrl %0d errors %0d", cur_name,
                 (err_cnt == err_before) ? "ok" : "failed", data_seen, ctrl_seen,
                 err_cnt - err_before);
    endtask

    // Ready pattern for both outputs
    initial begin
        data_out_rdy = 1'b1;
        ctrl_out_rdy = 1'b1;
        rdy_state    = ~SEED;
        forever begin
            @(posedge clk);
            #1;
            rdy_state    = lcg_next(rdy_state);
            data_out_rdy = (rdy_state[31:16] % 100) >= bp_pct;
            rdy_state    = lcg_next(rdy_state);
            ctrl_out_rdy = (rdy_state[31:16] % 100) >= bp_pct;
        end
    end

    // Output monitors, sampled mid-cycle where everything is settled
    initial begin
        forever begin
            @(negedge clk);
            if (arst_n === 1'b1 && data_out_val && data_out_rdy) begin
                data_seen++;
                if (exp_data_q.size() == 0) begin
                    $display("unexpected flit %h on data output in %s", data_out_data, cur_name);
                    err_cnt++;
                end else begin
                    check_value("data output", exp_data_q.pop_front(), data_out_data);
                end
            end
            if (arst_n === 1'b1 && ctrl_out_val && ctrl_out_rdy) begin
                ctrl_seen++;
                if (exp_ctrl_q.size() == 0) begin
                    $display("unexpected flit %h on ctrl output in %s", ctrl_out_data, cur_name);
                    err_cnt++;
                end else begin
                    check_value("ctrl output", exp_ctrl_q.pop_front(), ctrl_out_data);
                end
            end
        end
    end

    initial begin
        int waited;
        in_val       = 1'b0;
        in_data      = '0;
        pay_state    = SEED;
        bp_pct       = 0;
        err_cnt      = 0;
        tests_failed = 0;
        data_seen    = 0;
        ctrl_seen    = 0;
        waited       = 0;

        //      idx name            msgs fbits      lengths                                      bp data ctrl
        set_row(0, "pkt_only",      3, 24'h000222, {8'd0, 8'd0, 8'd0, 8'd0, 8'd4, 8'd1},      0,  8,  0);
        set_row(1, "ctrl_only",     3, 24'h000905, {8'd0, 8'd0, 8'd0, 8'd3, 8'd0, 8'd2},      0,  0, 16);
        set_row(2, "interleave",    4, 24'h001272, {8'd0, 8'd0, 8'd1, 8'd0, 8'd2, 8'd3},      0,  5, 10);
        set_row(3, "backpressure",  6, 24'h2f2232, {8'd1, 8'd7, 8'd0, 8'd2, 8'd4, 8'd5},     40, 12, 26);
        set_row(4, "hdr_only",      6, 24'h244242, {8'd3, 8'd0, 8'd0, 8'd0, 8'd0, 8'd0},     30,  6,  6);
        set_row(5, "max_len",       3, 24'h000626, {8'd0, 8'd0, 8'd0, 8'd0, 8'd20, 8'd127},  25, 21, 258);

        // Both valids must stay low through reset and while idle
        cur_name = "reset_idle";
        while (arst_n !== 1'b1) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("timeout: reset was never released");
            end
            @(negedge clk);
            check_value("valids in reset", 2'b00, {data_out_val, ctrl_out_val});
        end
        repeat (5) begin
            @(negedge clk);
            check_value("valids after reset", 2'b00, {data_out_val, ctrl_out_val});
        end
        if (err_cnt != 0) begin
            tests_failed++;
        end
        $display("test %-13s %-6s errors %0d", cur_name, (err_cnt == 0) ? "ok" : "failed",
                 err_cnt);

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS + 1, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* src.f */
logic/steer_pkg.sv
logic/noc_msg_splitter.sv
logic/noc_data_to_ctrl.sv
logic/udp_rx_out_steer.sv
sim/clk_rst_gen.sv
sim/udp_rx_out_steer_tb.sv
